// File: logic/scope_cmd_pkg.sv
// scope command processor shared definitions
// frame layout, opcodes, trigger types, acquisition state codes and trigger config

`default_nettype none

package scope_cmd_pkg;

	//------------------------------------------------------------
	// sizes
	//------------------------------------------------------------
	localparam int SAMPLE_W  = 12; // adc sample width
	localparam int CMD_BYTES = 8;  // bytes per command frame

	typedef logic signed [SAMPLE_W-1:0] sample_t; // two's complement adc sample

	//------------------------------------------------------------
	// opcodes, first byte of a frame
	//------------------------------------------------------------
	localparam logic [7:0] OP_RELEASE  = 8'd0; // release a finished event
	localparam logic [7:0] OP_ARM      = 8'd1; // set type and length, arm if idle
	localparam logic [7:0] OP_INFO     = 8'd2; // version or event count
	localparam logic [7:0] OP_TRIG_SET = 8'd8; // level, hysteresis, tot

	typedef enum logic [7:0] {
		TRIG_NONE = 8'd0, // immediate, no qualification
		TRIG_RISE = 8'd1, // rising edge threshold
		TRIG_FALL = 8'd2, // falling edge threshold
		TRIG_EXT  = 8'd3  // external trigger input
	} trig_type_e;

	// host software decodes these values, keep them fixed
	typedef enum logic [7:0] {
		ACQ_READY     = 8'd0,   // idle, waiting for arm
		ACQ_RISE_LOW  = 8'd1,   // waiting for sample below lower threshold
		ACQ_RISE_HIGH = 8'd2,   // counting samples above upper threshold
		ACQ_FALL_HIGH = 8'd3,   // waiting for sample above upper threshold
		ACQ_FALL_LOW  = 8'd4,   // counting samples below lower threshold
		ACQ_EXT_WAIT  = 8'd5,   // waiting for external trigger
		ACQ_POST      = 8'd250, // triggered, taking post-trigger samples
		ACQ_DONE      = 8'd251  // event complete, waiting for release
	} acq_state_e;

	//------------------------------------------------------------
	// argument views of frame bytes 1..7
	//------------------------------------------------------------
	typedef struct packed {
		trig_type_e trig_type;   // byte 1
		logic [7:0] rsvd1;       // byte 2
		logic [7:0] rsvd2;       // byte 3
		logic [7:0] post_len_lo; // byte 4
		logic [7:0] post_len_hi; // byte 5
		logic [15:0] pad;        // bytes 6..7
	} arm_args_t;

	typedef struct packed {
		logic [7:0]  level; // byte 1, threshold center in adc/16 units
		logic [7:0]  hyst;  // byte 2
		logic [7:0]  tot;   // byte 3, extra samples needed past threshold
		logic [31:0] pad;   // bytes 4..7
	} trig_set_args_t;

	typedef struct packed {
		logic [7:0]  sel; // byte 1, 0 version / 1 event count
		logic [47:0] pad; // bytes 2..7
	} info_args_t;

	typedef union packed {
		arm_args_t      arm;
		trig_set_args_t trig_set;
		info_args_t     info;
	} cmd_args_u;

	typedef struct packed {
		logic [7:0] opcode; // byte 0, first on the wire
		cmd_args_u  args;
	} cmd_frame_t;

	// settings handed to the acquisition engine on arm
	typedef struct packed {
		trig_type_e  trig_type;
		sample_t     lower;    // lower threshold
		sample_t     upper;    // upper threshold
		logic [7:0]  tot;      // time over threshold
		logic [15:0] post_len; // samples after trigger
	} trig_cfg_t;

endpackage

`default_nettype wire

// File: logic/cmd_frame_rx.sv
// command frame receiver
// packs 8 bytes of the input stream into one frame, flags it for one cycle

`timescale 1ns/10ps
`default_nettype none

module cmd_frame_rx (
	input  wire                       clk,
	input  wire                       rstn,
	input  wire                       i_rx_valid,
	input  wire  [7:0]                i_rx_data,
	output logic                      o_rx_ready,
	input  wire                       i_busy,      // executor still working on last frame
	output logic                      o_frame_vld,
	output scope_cmd_pkg::cmd_frame_t o_frame
);

	logic [2:0]  byte_cnt;  // bytes taken in current frame
	logic [63:0] shift_q;   // byte 0 ends up in the top byte
	logic        rx_fire;
	logic        last_byte;

	assign rx_fire   = i_rx_valid & o_rx_ready;
	assign last_byte = (byte_cnt == 3'(scope_cmd_pkg::CMD_BYTES - 1));

	// frame_vld marks a pending frame, executor raises busy from then on
	assign o_rx_ready = ~i_busy & ~o_frame_vld;
	assign o_frame    = scope_cmd_pkg::cmd_frame_t'(shift_q);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			byte_cnt    <= '0;
			o_frame_vld <= 1'b0;
		end else begin
			o_frame_vld <= rx_fire & last_byte; // one cycle after 8th byte
			if (rx_fire)
				byte_cnt <= byte_cnt + 3'd1; // wraps to 0 after byte 7
		end
	end

	always_ff @(posedge clk) begin
		if (rx_fire)
			shift_q <= {shift_q[55:0], i_rx_data};
	end

	// executor must hold busy while a frame is pending
	a_busy_with_frame: assert property (
		@(posedge clk) disable iff (!rstn)
		o_frame_vld |-> i_busy
	);

endmodule

`default_nettype wire

// File: logic/cmd_exec.sv
// command executor
// decodes frames, keeps trigger settings, arms/releases acquisition,
// returns one 32-bit response word per known command

`timescale 1ns/10ps
`default_nettype none

module cmd_exec #(
	parameter logic [31:0] FW_VERSION = 32'd0
) (
	input  wire                       clk,
	input  wire                       rstn,
	input  wire                       i_frame_vld,
	input  wire scope_cmd_pkg::cmd_frame_t i_frame,
	output logic                      o_busy,
	// response stream
	output logic                      o_tx_valid,
	output logic [31:0]               o_tx_data,
	input  wire                       i_tx_ready,
	// acquisition control
	output logic                      o_arm,
	output scope_cmd_pkg::trig_cfg_t  o_cfg,
	output logic                      o_release,
	input  wire scope_cmd_pkg::acq_state_e i_acq_state,
	input  wire [15:0]                i_event_count
);

	scope_cmd_pkg::cmd_args_u args;
	scope_cmd_pkg::sample_t   thr_lo;
	scope_cmd_pkg::sample_t   thr_hi;
	logic [11:0]              level_x;    // level widened to threshold width
	logic [11:0]              hyst_x;
	logic [31:0]              resp_word;
	logic                     resp_known; // opcode produces a response

	assign args    = i_frame.args;
	assign level_x = {4'd0, args.trig_set.level};
	assign hyst_x  = {4'd0, args.trig_set.hyst};

	// 16*(level -/+ hyst - 128) + 8, kept to 12 bits and read as signed
	assign thr_lo = ((level_x - hyst_x - 12'd128) << 4) + 12'd8;
	assign thr_hi = ((level_x + hyst_x - 12'd128) << 4) + 12'd8;

	// busy covers the frame_vld cycle and the whole response hold
	assign o_busy = i_frame_vld | o_tx_valid;

	//------------------------------------------------------------
	// response word
	//------------------------------------------------------------
	always_comb begin
		resp_word  = '0;
		resp_known = 1'b1;
		case (i_frame.opcode)
			scope_cmd_pkg::OP_RELEASE: resp_word = {24'd0, i_acq_state};
			scope_cmd_pkg::OP_ARM:     resp_word = {24'd0, i_acq_state}; // state before arming
			scope_cmd_pkg::OP_INFO: begin
				case (args.info.sel)
					8'd0:    resp_word = FW_VERSION;
					8'd1:    resp_word = {16'd0, i_event_count};
					default: resp_word = '0;
				endcase
			end
			scope_cmd_pkg::OP_TRIG_SET: resp_word = {24'd0, scope_cmd_pkg::OP_TRIG_SET}; // echo 8
			default: resp_known = 1'b0; // dropped silently
		endcase
	end

	//------------------------------------------------------------
	// control and settings
	//------------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_tx_valid <= 1'b0;
			o_arm      <= 1'b0;
			o_release  <= 1'b0;
			o_cfg      <= '0;
		end else begin
			o_arm     <= 1'b0; // pulses
			o_release <= 1'b0;
			if (o_tx_valid && i_tx_ready)
				o_tx_valid <= 1'b0; // word taken
			if (i_frame_vld) begin
				o_tx_valid <= resp_known;
				case (i_frame.opcode)
					scope_cmd_pkg::OP_TRIG_SET: begin
						o_cfg.lower <= thr_lo;
						o_cfg.upper <= thr_hi;
						o_cfg.tot   <= args.trig_set.tot;
					end
					scope_cmd_pkg::OP_ARM: begin
						o_cfg.trig_type <= args.arm.trig_type;
						o_cfg.post_len  <= {args.arm.post_len_hi, args.arm.post_len_lo};
						o_arm           <= (i_acq_state == scope_cmd_pkg::ACQ_READY); // only from idle
					end
					scope_cmd_pkg::OP_RELEASE: o_release <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	// response payload, loaded with the valid flag
	always_ff @(posedge clk) begin
		if (i_frame_vld && resp_known)
			o_tx_data <= resp_word;
	end

	// held word must not change until the host takes it
	a_tx_hold: assert property (
		@(posedge clk) disable iff (!rstn)
		(o_tx_valid && !i_tx_ready) |=> (o_tx_valid && $stable(o_tx_data))
	);

endmodule

`default_nettype wire

// File: logic/edge_trigger.sv
// acquisition engine
// threshold trigger with time-over-threshold qualification, external and
// immediate trigger, post-trigger sample count and event counter

`timescale 1ns/10ps
`default_nettype none

module edge_trigger (
	input  wire                       clk,
	input  wire                       rstn,
	input  wire                       i_arm,
	input  wire scope_cmd_pkg::trig_cfg_t i_cfg,
	input  wire                       i_release,
	input  wire scope_cmd_pkg::sample_t   i_sample,
	input  wire                       i_sample_vld,
	input  wire                       i_ext_trig,   // level from other boards
	output logic                      o_trig_out,   // tell other boards
	output scope_cmd_pkg::acq_state_e o_acq_state,
	output logic [15:0]               o_event_count
);

	scope_cmd_pkg::trig_cfg_t cfg_q;    // settings captured on arm
	logic [7:0]               tot_cnt;  // samples past threshold so far
	logic [15:0]              post_cnt; // samples since trigger
	logic                     above;    // sample over upper threshold
	logic                     below;    // sample under lower threshold

	assign above = i_sample_vld && (i_sample > cfg_q.upper);
	assign below = i_sample_vld && (i_sample < cfg_q.lower);

	//------------------------------------------------------------
	// state machine
	//------------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_acq_state   <= scope_cmd_pkg::ACQ_READY;
			o_trig_out    <= 1'b0;
			o_event_count <= '0;
			tot_cnt       <= '0;
			post_cnt      <= '0;
		end else begin
			o_trig_out <= 1'b0; // single cycle
			case (o_acq_state)
				scope_cmd_pkg::ACQ_READY: begin
					tot_cnt  <= '0;
					post_cnt <= '0;
					if (i_arm) begin
						case (i_cfg.trig_type)
							scope_cmd_pkg::TRIG_RISE: o_acq_state <= scope_cmd_pkg::ACQ_RISE_LOW;
							scope_cmd_pkg::TRIG_FALL: o_acq_state <= scope_cmd_pkg::ACQ_FALL_HIGH;
							scope_cmd_pkg::TRIG_EXT:  o_acq_state <= scope_cmd_pkg::ACQ_EXT_WAIT;
							default:                  o_acq_state <= scope_cmd_pkg::ACQ_POST; // immediate
						endcase
					end
				end

				// rising edge
				scope_cmd_pkg::ACQ_RISE_LOW: begin
					if (below)
						o_acq_state <= scope_cmd_pkg::ACQ_RISE_HIGH; // was low, now look for high
				end
				scope_cmd_pkg::ACQ_RISE_HIGH: begin
					if (above) begin
						tot_cnt <= tot_cnt + 8'd1;
						if (tot_cnt >= cfg_q.tot) begin // tot+1 samples in a row
							o_trig_out  <= 1'b1;
							o_acq_state <= scope_cmd_pkg::ACQ_POST;
						end
					end else if (i_sample_vld) begin
						tot_cnt     <= '0; // dropped back, start over
						o_acq_state <= scope_cmd_pkg::ACQ_RISE_LOW;
					end
				end

				// falling edge, mirror of rising
				scope_cmd_pkg::ACQ_FALL_HIGH: begin
					if (above)
						o_acq_state <= scope_cmd_pkg::ACQ_FALL_LOW;
				end
				scope_cmd_pkg::ACQ_FALL_LOW: begin
					if (below) begin
						tot_cnt <= tot_cnt + 8'd1;
						if (tot_cnt >= cfg_q.tot) begin
							o_trig_out  <= 1'b1;
							o_acq_state <= scope_cmd_pkg::ACQ_POST;
						end
					end else if (i_sample_vld) begin
						tot_cnt     <= '0;
						o_acq_state <= scope_cmd_pkg::ACQ_FALL_HIGH;
					end
				end

				scope_cmd_pkg::ACQ_EXT_WAIT: begin
					if (i_ext_trig) begin
						o_trig_out  <= 1'b1;
						o_acq_state <= scope_cmd_pkg::ACQ_POST;
					end
				end

				// post-trigger samples, then the event is complete
				scope_cmd_pkg::ACQ_POST: begin
					if (post_cnt >= cfg_q.post_len) begin
						o_event_count <= o_event_count + 16'd1;
						o_acq_state   <= scope_cmd_pkg::ACQ_DONE;
					end else if (i_sample_vld) begin
						post_cnt <= post_cnt + 16'd1;
					end
				end

				scope_cmd_pkg::ACQ_DONE: begin
					if (i_release)
						o_acq_state <= scope_cmd_pkg::ACQ_READY; // host has the event
				end

				default: o_acq_state <= scope_cmd_pkg::ACQ_READY;
			endcase
		end
	end

	// settings stay fixed for the whole acquisition
	always_ff @(posedge clk) begin
		if (i_arm && o_acq_state == scope_cmd_pkg::ACQ_READY)
			cfg_q <= i_cfg;
	end

	// executor only arms after reading back an idle state
	a_arm_only_ready: assert property (
		@(posedge clk) disable iff (!rstn)
		i_arm |-> (o_acq_state == scope_cmd_pkg::ACQ_READY)
	);

endmodule

`default_nettype wire

// File: logic/scope_cmd_top.sv
// scope command processor top
// byte stream in, response words out, trigger engine on the adc sample stream

`timescale 1ns/10ps
`default_nettype none

module scope_cmd_top #(
	parameter logic [31:0] FW_VERSION = 32'd19
) (
	input  wire                     clk,
	input  wire                     rstn,
	// command bytes
	input  wire                     i_rx_valid,
	input  wire  [7:0]              i_rx_data,
	output logic                    o_rx_ready,
	// response words
	output logic                    o_tx_valid,
	output logic [31:0]             o_tx_data,
	input  wire                     i_tx_ready,
	// adc and trigger lines
	input  wire scope_cmd_pkg::sample_t i_sample,
	input  wire                     i_sample_vld,
	input  wire                     i_ext_trig,
	output logic                    o_trig_out
);

	logic                      frame_vld;
	scope_cmd_pkg::cmd_frame_t frame;
	logic                      busy;
	logic                      arm;
	logic                      acq_release;
	scope_cmd_pkg::trig_cfg_t  cfg;
	scope_cmd_pkg::acq_state_e acq_state;
	logic [15:0]               event_count;

	cmd_frame_rx u_rx (
		.clk         (clk),
		.rstn        (rstn),
		.i_rx_valid  (i_rx_valid),
		.i_rx_data   (i_rx_data),
		.o_rx_ready  (o_rx_ready),
		.i_busy      (busy),
		.o_frame_vld (frame_vld),
		.o_frame     (frame)
	);

	cmd_exec #(
		.FW_VERSION (FW_VERSION)
	) u_exec (
		.clk           (clk),
		.rstn          (rstn),
		.i_frame_vld   (frame_vld),
		.i_frame       (frame),
		.o_busy        (busy),
		.o_tx_valid    (o_tx_valid),
		.o_tx_data     (o_tx_data),
		.i_tx_ready    (i_tx_ready),
		.o_arm         (arm),
		.o_cfg         (cfg),
		.o_release     (acq_release),
		.i_acq_state   (acq_state),
		.i_event_count (event_count)
	);

	edge_trigger u_trig (
		.clk           (clk),
		.rstn          (rstn),
		.i_arm         (arm),
		.i_cfg         (cfg),
		.i_release     (acq_release),
		.i_sample      (i_sample),
		.i_sample_vld  (i_sample_vld),
		.i_ext_trig    (i_ext_trig),
		.o_trig_out    (o_trig_out),
		.o_acq_state   (acq_state),
		.o_event_count (event_count)
	);

endmodule

`default_nettype wire

// File: verif/scope_cmd_tasks.svh
// testbench helpers for the scope command processor
// clocking, byte and frame driver, response capture, sample feed and checks

`ifndef SCOPE_CMD_TASKS_SVH
`define SCOPE_CMD_TASKS_SVH

	//------------------------------------------------------------
	// timing and failure
	//------------------------------------------------------------
	task automatic next_cycle();
		@(posedge clk);
		#2; // inputs change just after the edge
	endtask

	task automatic abort_run(input string msg);
		$display("ERROR: %s", msg);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
			abort_run("value check failed");
		end
	endtask

	//------------------------------------------------------------
	// command stream
	//------------------------------------------------------------
	task automatic send_byte(input logic [7:0] b);
		int   n;
		logic took;
		i_rx_valid = 1'b1;
		i_rx_data  = b;
		took       = 1'b0;
		n          = 0;
		while (!took) begin
			if (n == WAIT_LIMIT)
				abort_run("o_rx_ready never came back while sending a byte");
			took = o_rx_ready; // stable between edges
			next_cycle();
			n++;
		end
		i_rx_valid = 1'b0;
	endtask

	task automatic send_frame(input logic [63:0] frame);
		for (int i = 7; i >= 0; i--)
			send_byte(frame[i*8 +: 8]); // byte 0 sits in the top byte
	endtask

	task automatic get_resp(output logic [31:0] data);
		int   n;
		logic seen;
		i_tx_ready = 1'b1;
		seen       = 1'b0;
		data       = '0;
		n          = 0;
		while (!seen) begin
			if (n == WAIT_LIMIT)
				abort_run("no response word arrived on o_tx_valid");
			seen = o_tx_valid;
			data = o_tx_data;
			next_cycle();
			n++;
		end
		i_tx_ready = 1'b0;
	endtask

	// one full command, response compared against the expected word
	task automatic run_cmd(input logic [63:0] frame, input logic [31:0] exp, input string name);
		logic [31:0] resp;
		send_frame(frame);
		get_resp(resp);
		check_val(name, resp, exp);
	endtask

	task automatic wait_tx_valid();
		int n;
		n = 0;
		while (!o_tx_valid) begin
			if (n == WAIT_LIMIT)
				abort_run("o_tx_valid did not rise after a frame");
			next_cycle();
			n++;
		end
	endtask

	// an unknown opcode must free the input without any response
	task automatic wait_rx_ready();
		int n;
		n = 0;
		while (!o_rx_ready) begin
			if (o_tx_valid)
				abort_run("response word sent for an unknown opcode");
			if (n == WAIT_LIMIT)
				abort_run("o_rx_ready stayed low after an unknown opcode");
			next_cycle();
			n++;
		end
	endtask

	//------------------------------------------------------------
	// adc samples
	//------------------------------------------------------------
	task automatic feed_sample(input logic signed [11:0] s, output logic trig);
		i_sample     = s;
		i_sample_vld = 1'b1;
		next_cycle();
		trig         = o_trig_out; // pulse shows one cycle after the sample
		i_sample_vld = 1'b0;
	endtask

`endif

// File: verif/scope_cmd_tb.sv
// scope command processor testbench
// directed tests for info, threshold, external and immediate triggers, back-pressure

`timescale 1ns/10ps
`default_nettype none

module scope_cmd_tb;

	localparam int          WAIT_LIMIT = 200;     // cycles per wait loop
	localparam logic [31:0] RESP_READY = 32'd0;   // acq state idle
	localparam logic [31:0] RESP_DONE  = 32'd251; // acq state event complete
	localparam logic [31:0] RESP_TSET  = 32'd8;   // trig set echo
	localparam logic [31:0] FW_EXPECT  = 32'd19;

	// level 128, hyst 2 gives lower -24 and upper 40
	localparam logic signed [11:0] S_HIGH = 12'sd100;
	localparam logic signed [11:0] S_LOW  = -12'sd100;
	localparam logic signed [11:0] S_MID  = 12'sd0;

	logic                   clk;
	logic                   rstn;
	logic                   i_rx_valid;
	logic [7:0]             i_rx_data;
	logic                   o_rx_ready;
	logic                   o_tx_valid;
	logic [31:0]            o_tx_data;
	logic                   i_tx_ready;
	scope_cmd_pkg::sample_t i_sample;
	logic                   i_sample_vld;
	logic                   i_ext_trig;
	logic                   o_trig_out;
	int                     trig_pulses; // o_trig_out cycles seen so far
	integer                 seed;

	scope_cmd_top #(
		.FW_VERSION (32'd19)
	) i_dut (
		.clk          (clk),
		.rstn         (rstn),
		.i_rx_valid   (i_rx_valid),
		.i_rx_data    (i_rx_data),
		.o_rx_ready   (o_rx_ready),
		.o_tx_valid   (o_tx_valid),
		.o_tx_data    (o_tx_data),
		.i_tx_ready   (i_tx_ready),
		.i_sample     (i_sample),
		.i_sample_vld (i_sample_vld),
		.i_ext_trig   (i_ext_trig),
		.o_trig_out   (o_trig_out)
	);

	always #20 clk = ~clk; // 40 ns period

	always @(negedge clk) begin
		if (rstn && o_trig_out)
			trig_pulses = trig_pulses + 1; // mid-cycle, outputs settled
	end

	`include "scope_cmd_tasks.svh"

	//------------------------------------------------------------
	// frame builders, byte 0 in the top byte
	//------------------------------------------------------------
	function automatic logic [63:0] info_frame(input logic [7:0] sel);
		return {scope_cmd_pkg::OP_INFO, sel, 48'd0};
	endfunction

	function automatic logic [63:0] arm_frame(input logic [7:0] ttype, input logic [15:0] len);
		return {scope_cmd_pkg::OP_ARM, ttype, 16'd0, len[7:0], len[15:8], 16'd0};
	endfunction

	function automatic logic [63:0] tset_frame(input logic [7:0] lvl, input logic [7:0] hyst,
		input logic [7:0] tot);
		return {scope_cmd_pkg::OP_TRIG_SET, lvl, hyst, tot, 32'd0};
	endfunction

	function automatic logic [63:0] release_frame();
		return {scope_cmd_pkg::OP_RELEASE, 56'd0};
	endfunction

	//------------------------------------------------------------
	// directed tests
	//------------------------------------------------------------
	task automatic info_and_unknown_op();
		run_cmd(info_frame(8'd0), FW_EXPECT, "o_tx_data fw version");
		send_frame({8'h55, 56'd0}); // not a valid opcode
		wait_rx_ready();
		check_val("o_tx_valid", 32'(o_tx_valid), 32'd0);
		run_cmd(info_frame(8'd0), FW_EXPECT, "o_tx_data fw version after unknown");
	endtask

	task automatic rising_edge_tot();
		logic trig;
		run_cmd(tset_frame(8'd128, 8'd2, 8'd3), RESP_TSET, "o_tx_data trig set");
		run_cmd(arm_frame(scope_cmd_pkg::TRIG_RISE, 16'd5), RESP_READY, "o_tx_data arm rise");
		for (int i = 0; i < 3; i++) begin
			feed_sample(S_LOW, trig); // odd count leaves the engine waiting high
			check_val("o_trig_out", 32'(trig), 32'd0);
		end
		for (int i = 0; i < 3; i++) begin
			feed_sample(S_HIGH, trig); // one short of tot+1
			check_val("o_trig_out", 32'(trig), 32'd0);
		end
		feed_sample(S_MID, trig);
		check_val("o_trig_out", 32'(trig), 32'd0);
		feed_sample(S_LOW, trig);
		check_val("o_trig_out", 32'(trig), 32'd0);
		for (int i = 0; i < 4; i++) begin
			feed_sample(S_HIGH, trig);
			check_val("o_trig_out", 32'(trig), (i == 3) ? 32'd1 : 32'd0);
		end
		for (int i = 0; i < 5; i++)
			feed_sample(S_MID, trig);
		run_cmd(arm_frame(scope_cmd_pkg::TRIG_RISE, 16'd5), RESP_DONE, "o_tx_data arm when done");
		run_cmd(info_frame(8'd1), 32'd1, "o_tx_data event count");
		check_val("trig_pulses", 32'(trig_pulses), 32'd1);
	endtask

	task automatic falling_edge();
		logic trig;
		run_cmd(release_frame(), RESP_DONE, "o_tx_data release");
		run_cmd(tset_frame(8'd128, 8'd2, 8'd0), RESP_TSET, "o_tx_data trig set tot 0");
		run_cmd(arm_frame(scope_cmd_pkg::TRIG_FALL, 16'd3), RESP_READY, "o_tx_data arm fall");
		feed_sample(S_HIGH, trig);
		check_val("o_trig_out", 32'(trig), 32'd0);
		feed_sample(S_LOW, trig); // tot 0 fires on first sample below
		check_val("o_trig_out", 32'(trig), 32'd1);
		for (int i = 0; i < 3; i++)
			feed_sample(S_MID, trig);
		run_cmd(info_frame(8'd1), 32'd2, "o_tx_data event count");
		check_val("trig_pulses", 32'(trig_pulses), 32'd2);
	endtask

	task automatic external_trigger();
		logic trig;
		run_cmd(release_frame(), RESP_DONE, "o_tx_data release");
		run_cmd(arm_frame(scope_cmd_pkg::TRIG_EXT, 16'd2), RESP_READY, "o_tx_data arm ext");
		for (int i = 0; i < 4; i++) begin
			feed_sample((i % 2 == 0) ? S_HIGH : S_LOW, trig); // samples are ignored
			check_val("o_trig_out", 32'(trig), 32'd0);
		end
		i_ext_trig = 1'b1;
		next_cycle();
		check_val("o_trig_out", 32'(o_trig_out), 32'd1);
		i_ext_trig = 1'b0;
		next_cycle();
		check_val("o_trig_out", 32'(o_trig_out), 32'd0);
		for (int i = 0; i < 2; i++)
			feed_sample(S_MID, trig);
		run_cmd(info_frame(8'd1), 32'd3, "o_tx_data event count");
		check_val("trig_pulses", 32'(trig_pulses), 32'd3);
	endtask

	task automatic immediate_trigger();
		logic trig;
		run_cmd(release_frame(), RESP_DONE, "o_tx_data release");
		run_cmd(arm_frame(scope_cmd_pkg::TRIG_NONE, 16'd4), RESP_READY, "o_tx_data arm none");
		for (int i = 0; i < 4; i++) begin
			feed_sample(S_HIGH, trig);
			check_val("o_trig_out", 32'(trig), 32'd0);
		end
		run_cmd(arm_frame(scope_cmd_pkg::TRIG_NONE, 16'd4), RESP_DONE, "o_tx_data acq state");
		run_cmd(info_frame(8'd1), 32'd4, "o_tx_data event count");
		check_val("trig_pulses", 32'(trig_pulses), 32'd3);
	endtask

	task automatic response_backpressure();
		int          stall;
		logic [31:0] held;
		logic [31:0] resp;
		stall = ($random(seed) & 32'h7fff_ffff) % 20 + 1; // 1..20 cycles
		send_frame(info_frame(8'd0));
		wait_tx_valid();
		held = o_tx_data;
		for (int i = 0; i < stall; i++) begin
			next_cycle(); // edge passes with i_tx_ready low
			check_val("o_tx_valid", 32'(o_tx_valid), 32'd1);
			check_val("o_tx_data", o_tx_data, held);
			check_val("o_rx_ready", 32'(o_rx_ready), 32'd0);
		end
		get_resp(resp);
		check_val("o_tx_data after stall", resp, FW_EXPECT);
	endtask

	//------------------------------------------------------------
	// main sequence
	//------------------------------------------------------------
	initial begin
		clk          = 1'b0;
		rstn         = 1'b0;
		i_rx_valid   = 1'b0;
		i_rx_data    = 8'd0;
		i_tx_ready   = 1'b0;
		i_sample     = '0;
		i_sample_vld = 1'b0;
		i_ext_trig   = 1'b0;
		trig_pulses  = 0;
		seed         = 17;
		repeat (16) @(posedge clk);
		#2 rstn = 1'b1;
		next_cycle();
		check_val("o_rx_ready", 32'(o_rx_ready), 32'd1);
		check_val("o_tx_valid", 32'(o_tx_valid), 32'd0);
		check_val("o_trig_out", 32'(o_trig_out), 32'd0);
		info_and_unknown_op();
		rising_edge_tot();
		falling_edge();
		external_trigger();
		immediate_trigger();
		response_backpressure();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: scope_cmd_top.f
logic/scope_cmd_pkg.sv
logic/cmd_frame_rx.sv
logic/cmd_exec.sv
logic/edge_trigger.sv
logic/scope_cmd_top.sv
+incdir+verif
verif/scope_cmd_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the scope command processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f scope_cmd_top.f --top-module scope_cmd_tb -o scope_cmd_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/scope_cmd_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	exit 1
fi

if echo "$sim_out" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1
